/* hdl/byteSequencer.sv */
`timescale 1ns/10ps

module byteSequencer (
    input  logic                           clk,
    input  logic                           rst,

    memReqIf.sequencer                     bus,

    output logic [memPkg::AddrWidth-1:0]   memAddr,
    output logic                           memWrite,
    output logic [memPkg::ByteWidth-1:0]   memWdata,
    input  logic [memPkg::ByteWidth-1:0]   memRdata
);
    import memPkg::*;

    seqState_e            state;
    logic                 accept;

    // latched request
    memOp_e               opReg;
    logic [AddrWidth-1:0] addrReg;
    logic [DataWidth-1:0] wdataReg;
    reqSource_e           srcReg;
    logic [1:0]           lastIdx;

    // byte counter and read assembly
    logic [1:0]           cnt;
    logic [1:0]           prevIdx;
    logic [DataWidth-1:0] asmReg;

    function automatic logic [1:0] lastIndex(accessLen_e len);
        logic [1:0] idx;
        unique case (len)
            lenByte: idx = 2'd0;
            lenHalf: idx = 2'd1;
            default: idx = 2'd3;
        endcase
        return idx;
    endfunction

    assign accept  = bus.reqValid && bus.reqReady;
    // the byte that arrives now was addressed one cycle ago
    assign prevIdx = cnt - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            cnt   <= '0;
        end else begin
            unique case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stIssue;
                        cnt   <= '0;
                    end
                end
                stIssue: begin
                    if (cnt == lastIdx) begin
                        // loads need one more cycle for the final byte
                        state <= (opReg == opRead) ? stLast : stRespond;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                stLast: begin
                    state <= stRespond;
                end
                stRespond: begin
                    if (bus.rspReady) begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opReg    <= bus.op;
            addrReg  <= bus.addr;
            wdataReg <= bus.wdata;
            srcReg   <= bus.source;
            lastIdx  <= lastIndex(bus.len);
            // cleared here so short loads come out zero-extended
            asmReg   <= '0;
        end else if (state == stIssue && opReg == opRead && cnt != 2'd0) begin
            asmReg[prevIdx*ByteWidth +: ByteWidth] <= memRdata;
        end else if (state == stLast) begin
            asmReg[cnt*ByteWidth +: ByteWidth] <= memRdata;
        end
    end

    // memory side, little-endian byte order
    assign memAddr  = addrReg + AddrWidth'(cnt);
    assign memWrite = (state == stIssue) && (opReg == opWrite);
    assign memWdata = wdataReg[cnt*ByteWidth +: ByteWidth];

    // handshakes toward the arbiter
    assign bus.reqReady  = (state == stIdle);
    assign bus.rspValid  = (state == stRespond);
    assign bus.rdata     = asmReg;
    assign bus.rspSource = srcReg;

endmodule

/* hdl/memCtrl.sv */
`timescale 1ns/10ps

module memCtrl (
    input  logic                           clk,
    input  logic                           rst,

    // instruction fetch
    input  logic                           fetchValid,
    output logic                           fetchReady,
    input  logic [memPkg::AddrWidth-1:0]   fetchAddr,
    output logic                           fetchRspValid,
    input  logic                           fetchRspReady,
    output logic [memPkg::DataWidth-1:0]   fetchInst,

    // load/store
    input  logic                           dataValid,
    output logic                           dataReady,
    input  memPkg::memOp_e                 dataOp,
    input  memPkg::accessLen_e             dataLen,
    input  logic [memPkg::AddrWidth-1:0]   dataAddr,
    input  logic [memPkg::DataWidth-1:0]   dataWdata,
    output logic                           dataRspValid,
    input  logic                           dataRspReady,
    output logic [memPkg::DataWidth-1:0]   dataRdata,

    // byte-wide synchronous RAM
    output logic [memPkg::AddrWidth-1:0]   memAddr,
    output logic                           memWrite,
    output logic [memPkg::ByteWidth-1:0]   memWdata,
    input  logic [memPkg::ByteWidth-1:0]   memRdata,

    input  logic                           ioFull
);

    memReqIf bus ();

    reqArbiter reqArb (
        .clk           (clk),
        .rst           (rst),
        .fetchValid    (fetchValid),
        .fetchReady    (fetchReady),
        .fetchAddr     (fetchAddr),
        .dataValid     (dataValid),
        .dataReady     (dataReady),
        .dataOp        (dataOp),
        .dataLen       (dataLen),
        .dataAddr      (dataAddr),
        .dataWdata     (dataWdata),
        .ioFull        (ioFull),
        .fetchRspValid (fetchRspValid),
        .fetchRspReady (fetchRspReady),
        .fetchInst     (fetchInst),
        .dataRspValid  (dataRspValid),
        .dataRspReady  (dataRspReady),
        .dataRdata     (dataRdata),
        .bus           (bus.arbiter)
    );

    byteSequencer byteSeq (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.sequencer),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

/* hdl/memPkg.sv */
package memPkg;

    // byte addressed, 256 KiB space
    localparam int AddrWidth = 18;
    localparam int DataWidth = 32;
    localparam int ByteWidth = 8;

    // stores at or above this address go to the output buffer
    localparam logic [AddrWidth-1:0] IoBase = 18'h30000;

    typedef enum logic {
        opRead,
        opWrite
    } memOp_e;

    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen_e;

    typedef enum logic {
        srcFetch,
        srcData
    } reqSource_e;

    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stLast,
        stRespond
    } seqState_e;

endpackage

/* hdl/memReqIf.sv */
`timescale 1ns/10ps

interface memReqIf;
    import memPkg::*;

    // request, arbiter to sequencer
    logic                 reqValid;
    logic                 reqReady;
    memOp_e               op;
    accessLen_e           len;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    reqSource_e           source;

    // response, sequencer back to arbiter
    logic                 rspValid;
    logic                 rspReady;
    logic [DataWidth-1:0] rdata;
    // owner of the response, copied from source at acceptance
    reqSource_e           rspSource;

    modport arbiter (
        output reqValid, op, len, addr, wdata, source, rspReady,
        input  reqReady, rspValid, rdata, rspSource
    );

    modport sequencer (
        input  reqValid, op, len, addr, wdata, source, rspReady,
        output reqReady, rspValid, rdata, rspSource
    );

endinterface

/* hdl/reqArbiter.sv */
`timescale 1ns/10ps

module reqArbiter (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           fetchValid,
    output logic                           fetchReady,
    input  logic [memPkg::AddrWidth-1:0]   fetchAddr,

    input  logic                           dataValid,
    output logic                           dataReady,
    input  memPkg::memOp_e                 dataOp,
    input  memPkg::accessLen_e             dataLen,
    input  logic [memPkg::AddrWidth-1:0]   dataAddr,
    input  logic [memPkg::DataWidth-1:0]   dataWdata,

    input  logic                           ioFull,

    output logic                           fetchRspValid,
    input  logic                           fetchRspReady,
    output logic [memPkg::DataWidth-1:0]   fetchInst,

    output logic                           dataRspValid,
    input  logic                           dataRspReady,
    output logic [memPkg::DataWidth-1:0]   dataRdata,

    memReqIf.arbiter                       bus
);
    import memPkg::*;

    logic ioStore;
    logic dataEligible;
    logic dataSel;
    logic rspToFetch;

    // only stores into the I/O region wait on a full buffer
    assign ioStore      = (dataOp == opWrite) && (dataAddr >= IoBase);
    assign dataEligible = !(ioStore && ioFull);
    assign dataSel      = dataValid && dataEligible;

    // data has priority, fetch takes the slot otherwise
    assign bus.reqValid = dataSel || fetchValid;
    assign bus.op       = dataSel ? dataOp : opRead;
    assign bus.len      = dataSel ? dataLen : lenWord;
    assign bus.addr     = dataSel ? dataAddr : fetchAddr;
    assign bus.wdata    = dataWdata;
    assign bus.source   = dataSel ? srcData : srcFetch;

    assign dataReady  = bus.reqReady && dataEligible;
    assign fetchReady = bus.reqReady && !dataSel;

    // response steering by the tag kept in the sequencer
    assign rspToFetch = (bus.rspSource == srcFetch);

    assign fetchRspValid = bus.rspValid && rspToFetch;
    assign dataRspValid  = bus.rspValid && !rspToFetch;
    assign fetchInst     = bus.rdata;
    assign dataRdata     = bus.rdata;
    assign bus.rspReady  = rspToFetch ? fetchRspReady : dataRspReady;

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the memory controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module memCtrlTb \
    --Mdir obj_dir \
    -o memCtrlSim
status=$?
if [ $status -ne 0 ]; then
    echo "build error, status $status"
    exit $status
fi

./obj_dir/memCtrlSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation error, status $status"
    exit $status
fi
exit 0

/* sim/memCtrlTb.sv */
`timescale 1ns/10ps

module memCtrlTb;
    import memPkg::*;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 fetchValid, fetchReady, fetchRspValid, fetchRspReady;
    logic [AddrWidth-1:0] fetchAddr;
    logic [DataWidth-1:0] fetchInst;
    logic                 dataValid, dataReady, dataRspValid, dataRspReady;
    memOp_e               dataOp;
    accessLen_e           dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [DataWidth-1:0] dataWdata, dataRdata;
    logic [AddrWidth-1:0] memAddr;
    logic                 memWrite;
    logic [ByteWidth-1:0] memWdata;
    logic [ByteWidth-1:0] memRdata = '0;
    logic                 ioFull;

    logic [7:0]           mem    [0:(1<<AddrWidth)-1];
    logic [7:0]           shadow [0:(1<<AddrWidth)-1];

    // state of the request in flight
    logic                 busy, curFetch, curWrite, rspSeen, stimOn;
    logic                 fetchAcc, dataAcc;
    logic [AddrWidth-1:0] curAddr;
    logic [DataWidth-1:0] curWdata, curExp, rspFirst;
    int                   curLen, since, wrCnt, fetchWait, dataWait, drainCnt;

    memCtrl UUT (.*);

    always #20 clk = ~clk;

    // byte RAM, one cycle read latency
    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr] <= memWdata;
        end
        memRdata <= mem[memAddr];
    end

    function automatic logic [7:0] fillByte(int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
    endfunction

    function automatic int lenBytes(accessLen_e len);
        return (len == lenByte) ? 1 : (len == lenHalf) ? 2 : 4;
    endfunction

    // little-endian, upper bytes zero
    function automatic logic [31:0] loadValue(logic [AddrWidth-1:0] a, int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k*8 +: 8] = shadow[18'(a + k)];
        end
        return v;
    endfunction

    function automatic logic [AddrWidth-1:0] randAddr();
        return ($urandom % 2) ? 18'(18'h00100 + $urandom % 64) : 18'(IoBase + $urandom % 64);
    endfunction

    task automatic failValue(string name, logic [31:0] exp, logic [31:0] act);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic failText(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "check failed");
    endtask

    task automatic startReq(logic f, logic w, logic [AddrWidth-1:0] a, int n, logic [31:0] wd);
        busy     = 1'b1;
        curFetch = f;
        curWrite = w;
        curAddr  = a;
        curLen   = n;
        curWdata = wd;
        since    = 0;
        wrCnt    = 0;
        rspSeen  = 1'b0;
        if (w) begin
            for (int k = 0; k < n; k++) begin
                shadow[18'(a + k)] = wd[k*8 +: 8];
            end
        end else begin
            curExp = loadValue(a, n);
        end
    endtask

    task automatic drive();
        if (!(fetchValid && !fetchAcc)) begin
            fetchValid <= stimOn && ($urandom % 2 == 1);
            fetchAddr  <= randAddr();
        end
        if (!(dataValid && !dataAcc)) begin
            dataValid <= stimOn && ($urandom % 2 == 1);
            dataOp    <= ($urandom % 2) ? opWrite : opRead;
            dataLen   <= ($urandom % 3 == 0) ? lenByte : ($urandom % 2) ? lenHalf : lenWord;
            dataAddr  <= randAddr();
            dataWdata <= $urandom;
        end
        ioFull        <= ($urandom % 3 == 0);
        fetchRspReady <= ($urandom % 2 == 1);
        dataRspReady  <= ($urandom % 2 == 1);
    endtask

    // runs at the falling edge where every signal is settled
    task automatic monitor();
        logic                 rspV;
        logic                 rspR;
        logic [DataWidth-1:0] rspD;
        logic                 ioBlocked;
        fetchAcc  = fetchValid && fetchReady;
        dataAcc   = dataValid && dataReady;
        ioBlocked = (dataOp == opWrite) && (dataAddr >= IoBase) && ioFull;
        if (busy) begin
            since++;
            rspV = curFetch ? fetchRspValid : dataRspValid;
            rspR = curFetch ? fetchRspReady : dataRspReady;
            rspD = curFetch ? fetchInst : dataRdata;
            assert (!(curFetch ? dataRspValid : fetchRspValid))
                else failText("response valid on the wrong port");
            if (memWrite) begin
                assert (curWrite) else failText("memWrite high during a load");
                assert (memAddr == 18'(curAddr + wrCnt))
                    else failValue("memAddr", 32'(curAddr + wrCnt), 32'(memAddr));
                assert (memWdata == curWdata[wrCnt*8 +: 8])
                    else failValue("memWdata", 32'(curWdata[wrCnt*8 +: 8]), 32'(memWdata));
                wrCnt++;
            end
            if (rspV) begin
                if (!rspSeen) begin
                    assert (since == (curWrite ? curLen + 1 : curLen + 2))
                        else failValue("response latency", 32'(curWrite ? curLen + 1
                                       : curLen + 2), 32'(since));
                    rspSeen  = 1'b1;
                    rspFirst = rspD;
                end
                assert (!fetchReady && !dataReady)
                    else failText("request ready high while a response waits");
                // a held response keeps its data
                assert (rspD == rspFirst)
                    else failValue(curFetch ? "fetchInst" : "dataRdata", rspFirst, rspD);
                if (curFetch) begin
                    assert (fetchInst == curExp) else failValue("fetchInst", curExp, fetchInst);
                end else if (!curWrite) begin
                    assert (dataRdata == curExp) else failValue("dataRdata", curExp, dataRdata);
                end
                if (rspR) begin
                    if (curWrite) begin
                        assert (wrCnt == curLen)
                            else failValue("memWrite cycles", 32'(curLen), 32'(wrCnt));
                    end
                    busy = 1'b0;
                end
            end else if (rspSeen) begin
                failText("response dropped before its ready");
            end else if (since > 100) begin
                failText("timeout waiting for a response");
            end
        end else begin
            assert (!memWrite) else failText("memWrite high with no request in progress");
            assert (!fetchRspValid && !dataRspValid)
                else failText("response valid with no request in progress");
        end
        assert (!(fetchAcc && dataAcc)) else failText("both ports accepted together");
        // an eligible data request must win over a fetch
        if (fetchValid && dataValid && !ioBlocked) begin
            assert (!fetchAcc) else failText("fetch accepted ahead of a data request");
        end
        if (dataValid && ioBlocked) begin
            assert (!dataReady) else failText("I/O store accepted while ioFull is high");
        end
        if (dataAcc) begin
            startReq(1'b0, dataOp == opWrite, dataAddr, lenBytes(dataLen), dataWdata);
        end else if (fetchAcc) begin
            startReq(1'b1, 1'b0, fetchAddr, 4, '0);
        end
        fetchWait = (fetchValid && !fetchAcc) ? fetchWait + 1 : 0;
        dataWait  = (dataValid && !dataAcc) ? dataWait + 1 : 0;
        if (fetchWait > 300 || dataWait > 300) begin
            failText("timeout waiting for a request to be accepted");
        end
    endtask

    initial begin
        void'($urandom(32'h285a8fef));
        for (int i = 0; i < (1 << AddrWidth); i++) begin
            mem[i]    = fillByte(i);
            shadow[i] = fillByte(i);
        end
        rst = 1'b1;
        {fetchValid, fetchRspReady, dataValid, dataRspReady, ioFull} = '0;
        fetchAddr = '0;
        dataOp    = opRead;
        dataLen   = lenByte;
        dataAddr  = '0;
        dataWdata = '0;
        {busy, fetchAcc, dataAcc, stimOn} = '0;
        fetchWait = 0;
        dataWait  = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (fetchReady && dataReady && !fetchRspValid && !dataRspValid && !memWrite)
            else failText("wrong output state after reset");
        stimOn = 1'b1;
        for (int i = 0; i < 3000; i++) begin
            @(posedge clk);
            drive();
            @(negedge clk);
            monitor();
        end
        // let open requests finish
        stimOn = 1'b0;
        for (drainCnt = 0; (busy || fetchValid || dataValid) && drainCnt < 400; drainCnt++) begin
            @(posedge clk);
            drive();
            @(negedge clk);
            monitor();
        end
        if (busy || fetchValid || dataValid) begin
            $display("Error: requests still open at the end of the run");
            $display("Testbench failed");
            $fatal(1, "drain timeout");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* sim/memCtrl_asserts.sv */
`timescale 1ns/10ps

module memCtrlAsserts (
    input logic                           clk,
    input logic                           rst,
    input logic                           fetchValid,
    input logic                           fetchReady,
    input logic                           dataValid,
    input logic                           dataReady,
    input memPkg::memOp_e                 dataOp,
    input logic [memPkg::AddrWidth-1:0]   dataAddr,
    input logic                           ioFull,
    input logic                           fetchRspValid,
    input logic                           fetchRspReady,
    input logic [memPkg::DataWidth-1:0]   fetchInst,
    input logic                           dataRspValid,
    input logic                           dataRspReady,
    input logic [memPkg::DataWidth-1:0]   dataRdata
);
    import memPkg::*;

    // held response keeps its value
    fetchRspHeld: assert property (@(posedge clk) disable iff (rst)
        fetchRspValid && !fetchRspReady |=> fetchRspValid && $stable(fetchInst))
        else $error("fetch response changed under back-pressure");

    dataRspHeld: assert property (@(posedge clk) disable iff (rst)
        dataRspValid && !dataRspReady |=> dataRspValid && $stable(dataRdata))
        else $error("data response changed under back-pressure");

    noReadyWhileRsp: assert property (@(posedge clk) disable iff (rst)
        (fetchRspValid || dataRspValid) |-> !fetchReady && !dataReady)
        else $error("request ready high while a response waits");

    oneGrant: assert property (@(posedge clk) disable iff (rst)
        !(fetchValid && fetchReady && dataValid && dataReady))
        else $error("both ports granted in one cycle");

    ioStoreBlocked: assert property (@(posedge clk) disable iff (rst)
        dataValid && dataOp == opWrite && dataAddr >= IoBase && ioFull |-> !dataReady)
        else $error("I/O store accepted while ioFull is high");

endmodule

bind reqArbiter memCtrlAsserts arbChk (
    .clk           (clk),
    .rst           (rst),
    .fetchValid    (fetchValid),
    .fetchReady    (fetchReady),
    .dataValid     (dataValid),
    .dataReady     (dataReady),
    .dataOp        (dataOp),
    .dataAddr      (dataAddr),
    .ioFull        (ioFull),
    .fetchRspValid (fetchRspValid),
    .fetchRspReady (fetchRspReady),
    .fetchInst     (fetchInst),
    .dataRspValid  (dataRspValid),
    .dataRspReady  (dataRspReady),
    .dataRdata     (dataRdata)
);

/* src.f */
hdl/memPkg.sv
hdl/memReqIf.sv
hdl/reqArbiter.sv
hdl/byteSequencer.sv
hdl/memCtrl.sv
sim/memCtrl_asserts.sv
sim/memCtrlTb.sv
